//--- common/vecAluPkg.sv
`default_nettype none

package vecAluPkg;

	// ========================================================================
	// Geometry of the vector datapath
	// ========================================================================

	// Number of independent lanes in one vector
	localparam int nLanes = 4;

	// Width of a single lane operand and result
	localparam int laneW = 32;

	// Width of the thread tag that travels with an instruction
	localparam int tidW = 4;

	// Iterations taken by the shift-add multiplier and the restoring divider
	localparam int mdSteps = 32;

	// Step counter width inside the mul/div unit
	localparam int mdCntW = $clog2(mdSteps);

	// ========================================================================
	// Value types
	// ========================================================================

	// One lane operand or result
	typedef logic [laneW-1:0] laneVal_t;

	// Whole vector with lane 0 in the low bits
	typedef logic [nLanes*laneW-1:0] vecVal_t;

	// Thread tag returned together with the result
	typedef logic [tidW-1:0] tid_t;

	// Opcodes. The last three take the iterative path
	typedef enum logic [2:0] {
		opAdd  = 3'd0,
		opSub  = 3'd1,
		opAnd  = 3'd2,
		opOr   = 3'd3,
		opXor  = 3'd4,
		opMul  = 3'd5,
		opDivu = 3'd6,
		opRemu = 3'd7
	} aluOp_t;

	// Per lane sequencing
	typedef enum logic [1:0] {
		stIdle = 2'd0,
		stBusy = 2'd1,
		stDone = 2'd2
	} laneState_t;

	// Mul/div unit sequencing
	typedef enum logic [1:0] {
		mdIdle   = 2'd0,
		mdRun    = 2'd1,
		mdFinish = 2'd2
	} mdState_t;

endpackage

`default_nettype wire

//--- vecAlu/vecAluMulDiv.sv
`default_nettype none

module vecAluMulDiv (
	input  logic               clk,
	input  logic               arstN,
	input  logic               start,
	input  vecAluPkg::aluOp_t  mode,
	input  vecAluPkg::laneVal_t a,
	input  vecAluPkg::laneVal_t b,
	output logic               done,
	output vecAluPkg::laneVal_t res
);

	import vecAluPkg::*;

	// Sequencer state and iteration count
	mdState_t            stateR;
	logic [mdCntW-1:0]   cntR;

	// Operation latched at start so the result mux stays put after done
	aluOp_t              modeR;

	// The three working registers are shared by both algorithms.
	// For multiply accR is the running product, qR the multiplier shifted right
	// and bR the multiplicand shifted left.
	// For divide accR is the partial remainder, qR the dividend that turns
	// into the quotient and bR the fixed divisor
	laneVal_t            accR;
	laneVal_t            qR;
	laneVal_t            bR;

	// One restoring division step
	logic [laneW:0]      divTrial;
	logic                divFits;

	always_comb begin
		// Bring the next dividend bit down into the remainder
		divTrial = {accR, qR[laneW-1]};
		// Subtraction succeeds when the trial value covers the divisor
		divFits = divTrial >= {1'b0, bR};
	end

	// ========================================================================
	// Control
	// ========================================================================

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			stateR <= mdIdle;
			cntR <= '0;
		end else begin
			case (stateR)
				mdIdle: begin
					if (start) begin
						stateR <= mdRun;
						cntR <= '0;
					end
				end
				mdRun: begin
					cntR <= cntR + 1'b1;
					// The last step lands on this edge so the registers hold the answer next
					if (cntR == mdCntW'(mdSteps - 1)) begin
						stateR <= mdFinish;
					end
				end
				default: begin
					stateR <= mdIdle;
				end
			endcase
		end
	end

	// ========================================================================
	// Datapath
	// ========================================================================

	always_ff @(posedge clk) begin
		if (stateR == mdIdle && start) begin
			// Both algorithms start from the same operand placement
			modeR <= mode;
			accR <= '0;
			qR <= a;
			bR <= b;
		end else if (stateR == mdRun) begin
			if (modeR == opMul) begin
				// Add the shifted multiplicand when the current multiplier bit is set
				if (qR[0]) begin
					accR <= accR + bR;
				end
				bR <= bR << 1;
				qR <= qR >> 1;
			end else begin
				// A zero divisor always fits, which yields all ones and keeps the dividend
				if (divFits) begin
					accR <= divTrial[laneW-1:0] - bR;
				end else begin
					accR <= divTrial[laneW-1:0];
				end
				qR <= {qR[laneW-2:0], divFits};
			end
		end
	end

	// Done lasts the single mdFinish cycle
	assign done = (stateR == mdFinish);

	// Product for multiply, remainder for opRemu, quotient otherwise
	assign res = (modeR == opMul || modeR == opRemu) ? accR : qR;

	// The lane only starts a new sequence once the previous one has finished
	assert property (@(posedge clk) disable iff (!arstN) !(start && stateR == mdRun))
		else $error("mul/div start while a sequence is running");

endmodule

`default_nettype wire

//--- vecAlu/vecAluLane.sv
`default_nettype none

module vecAluLane (
	input  logic                clk,
	input  logic                arstN,
	input  logic                start,
	input  vecAluPkg::aluOp_t   op,
	input  vecAluPkg::laneVal_t a,
	input  vecAluPkg::laneVal_t b,
	output logic                done,
	output vecAluPkg::laneVal_t res
);

	import vecAluPkg::*;

	laneState_t stateR;
	laneVal_t   resR;

	// Single cycle result and the long operation decode
	laneVal_t   simpleRes;
	logic       isLong;

	// Mul/div handshake
	logic       mdStart;
	logic       mdDone;
	laneVal_t   mdRes;

	always_comb begin
		isLong = (op == opMul) || (op == opDivu) || (op == opRemu);
		case (op)
			opAdd:   simpleRes = a + b;
			opSub:   simpleRes = a - b;
			opAnd:   simpleRes = a & b;
			opOr:    simpleRes = a | b;
			opXor:   simpleRes = a ^ b;
			default: simpleRes = '0;
		endcase
	end

	// Long operations go straight to the iterative unit in the start cycle
	assign mdStart = start && isLong && (stateR == stIdle);

	vecAluMulDiv u_mulDiv (
		.clk   (clk),
		.arstN (arstN),
		.start (mdStart),
		.mode  (op),
		.a     (a),
		.b     (b),
		.done  (mdDone),
		.res   (mdRes)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			stateR <= stIdle;
		end else begin
			case (stateR)
				stIdle: begin
					if (start) begin
						stateR <= isLong ? stBusy : stDone;
					end
				end
				stBusy: begin
					if (mdDone) begin
						stateR <= stDone;
					end
				end
				default: begin
					stateR <= stIdle;
				end
			endcase
		end
	end

	// Result capture for both paths
	always_ff @(posedge clk) begin
		if (stateR == stIdle && start && !isLong) begin
			resR <= simpleRes;
		end else if (stateR == stBusy && mdDone) begin
			resR <= mdRes;
		end
	end

	assign done = (stateR == stDone);
	assign res = resR;

	// Each start produces exactly one single-cycle done pulse
	assert property (@(posedge clk) disable iff (!arstN) done |=> !done)
		else $error("lane done held for two cycles");

endmodule

`default_nettype wire

//--- vecAlu/vecAlu.sv
`default_nettype none

module vecAlu (
	input  logic               clk,
	input  logic               arstN,
	input  logic               start,
	input  vecAluPkg::aluOp_t  op,
	input  vecAluPkg::vecVal_t a,
	input  vecAluPkg::vecVal_t b,
	input  vecAluPkg::tid_t    tidIn,
	output logic               done,
	output vecAluPkg::vecVal_t res,
	output vecAluPkg::tid_t    tidOut
);

	import vecAluPkg::*;

	// Per lane completion and results packed in vector order
	logic [nLanes-1:0] laneDone;
	vecVal_t           laneRes;
	logic              allDone;

	// Tag of the instruction in flight and the one presented with the result
	tid_t              tidHoldR;
	tid_t              tidOutR;

	vecVal_t           resR;
	logic              doneR;

	// ========================================================================
	// Lanes
	// ========================================================================

	// Every lane gets the same opcode and start, and its own operand slice
	for (genvar g = 0; g < nLanes; g++) begin : gLane
		vecAluLane u_lane (
			.clk   (clk),
			.arstN (arstN),
			.start (start),
			.op    (op),
			.a     (a[g*laneW +: laneW]),
			.b     (b[g*laneW +: laneW]),
			.done  (laneDone[g]),
			.res   (laneRes[g*laneW +: laneW])
		);
	end

	// The vector completes when the slowest lane is done
	assign allDone = &laneDone;

	// ========================================================================
	// Tag and result registers
	// ========================================================================

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			doneR <= 1'b0;
		end else begin
			doneR <= allDone;
		end
	end

	// The tag is parked at start and moved to the output with the result,
	// so tidOut stays stable until the next instruction finishes
	always_ff @(posedge clk) begin
		if (start) begin
			tidHoldR <= tidIn;
		end
		if (allDone) begin
			resR <= laneRes;
			tidOutR <= tidHoldR;
		end
	end

	assign done = doneR;
	assign res = resR;
	assign tidOut = tidOutR;

	// All lanes run the same opcode, so their latencies must agree
	assert property (@(posedge clk) disable iff (!arstN) (|laneDone) |-> (&laneDone))
		else $error("lanes finished in different cycles");

endmodule

`default_nettype wire

//--- src/vecAluReqAck.sv
`default_nettype none

module vecAluReqAck (
	input  logic               clk,
	input  logic               arstN,
	input  logic               req,
	input  vecAluPkg::aluOp_t  op,
	input  vecAluPkg::vecVal_t a,
	input  vecAluPkg::vecVal_t b,
	input  vecAluPkg::tid_t    tidIn,
	input  logic               aluDone,
	input  vecAluPkg::vecVal_t aluRes,
	input  vecAluPkg::tid_t    aluTid,
	output logic               ack,
	output logic               start,
	output vecAluPkg::aluOp_t  aluOp,
	output vecAluPkg::vecVal_t aluA,
	output vecAluPkg::vecVal_t aluB,
	output vecAluPkg::tid_t    aluTidIn,
	output vecAluPkg::vecVal_t res,
	output vecAluPkg::tid_t    tidOut
);

	import vecAluPkg::*;

	// Handshake sequencing
	typedef enum logic [1:0] {
		raIdle       = 2'd0,
		raWaitAlu    = 2'd1,
		raAckHigh    = 2'd2,
		raWaitReqLow = 2'd3
	} raState_t;

	raState_t stateR;
	logic     accept;

	// A request is taken only from idle
	assign accept = (stateR == raIdle) && req;

	// ========================================================================
	// Four-phase control
	// ========================================================================

	// Coming out of reset the port first waits for req low.
	// A request still high across reset is never mistaken for a new one
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			stateR <= raWaitReqLow;
			start <= 1'b0;
		end else begin
			start <= accept;
			case (stateR)
				raIdle: begin
					if (req) begin
						stateR <= raWaitAlu;
					end
				end
				raWaitAlu: begin
					if (aluDone) begin
						stateR <= raAckHigh;
					end
				end
				raAckHigh: begin
					// Ack drops on the edge after the host releases req
					if (!req) begin
						stateR <= raIdle;
					end
				end
				default: begin
					if (!req) begin
						stateR <= raIdle;
					end
				end
			endcase
		end
	end

	// ========================================================================
	// Instruction and result capture
	// ========================================================================

	always_ff @(posedge clk) begin
		if (accept) begin
			aluOp <= op;
			aluA <= a;
			aluB <= b;
			aluTidIn <= tidIn;
		end
		// Result and tag are held for the whole ack phase
		if (stateR == raWaitAlu && aluDone) begin
			res <= aluRes;
			tidOut <= aluTid;
		end
	end

	assign ack = (stateR == raAckHigh);

	// Four-phase rule seen from the host side
	assert property (@(posedge clk) disable iff (!arstN) $fell(ack) |-> !$past(req))
		else $error("ack dropped while req was still high");

endmodule

`default_nettype wire

//--- src/vecAluTop.sv
`default_nettype none

module vecAluTop (
	input  logic               clk,
	input  logic               arstN,
	input  logic               req,
	input  vecAluPkg::aluOp_t  op,
	input  vecAluPkg::vecVal_t a,
	input  vecAluPkg::vecVal_t b,
	input  vecAluPkg::tid_t    tidIn,
	output logic               ack,
	output vecAluPkg::vecVal_t res,
	output vecAluPkg::tid_t    tidOut
);

	import vecAluPkg::*;

	// Captured instruction on its way to the datapath
	logic    start;
	aluOp_t  aluOp;
	vecVal_t aluA;
	vecVal_t aluB;
	tid_t    aluTidIn;

	// Completion coming back from the datapath
	logic    aluDone;
	vecVal_t aluRes;
	tid_t    aluTid;

	// Host handshake
	vecAluReqAck u_reqAck (
		.clk      (clk),
		.arstN    (arstN),
		.req      (req),
		.op       (op),
		.a        (a),
		.b        (b),
		.tidIn    (tidIn),
		.aluDone  (aluDone),
		.aluRes   (aluRes),
		.aluTid   (aluTid),
		.ack      (ack),
		.start    (start),
		.aluOp    (aluOp),
		.aluA     (aluA),
		.aluB     (aluB),
		.aluTidIn (aluTidIn),
		.res      (res),
		.tidOut   (tidOut)
	);

	// Vector datapath
	vecAlu u_vecAlu (
		.clk    (clk),
		.arstN  (arstN),
		.start  (start),
		.op     (aluOp),
		.a      (aluA),
		.b      (aluB),
		.tidIn  (aluTidIn),
		.done   (aluDone),
		.res    (aluRes),
		.tidOut (aluTid)
	);

endmodule

`default_nettype wire

//--- dv/vecAluTb.sv
`default_nettype none

module vecAluTb;

	import vecAluPkg::*;

	// Cycles allowed for each handshake edge before the run is abandoned
	localparam int ackTimeout = 100;

	// Longest extra hold of req after ack
	localparam int maxHold = 5;

	logic    clk;
	logic    arstN;
	logic    req;
	aluOp_t  op;
	vecVal_t a;
	vecVal_t b;
	tid_t    tidIn;
	logic    ack;
	vecVal_t res;
	tid_t    tidOut;

	int      seed;
	int      nTests;
	int      nFail;
	logic    abort;

	vecAluTop u_dut (
		.clk    (clk),
		.arstN  (arstN),
		.req    (req),
		.op     (op),
		.a      (a),
		.b      (b),
		.tidIn  (tidIn),
		.ack    (ack),
		.res    (res),
		.tidOut (tidOut)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// ========================================================================
	// One four-phase transaction with its checks
	// ========================================================================

	task automatic runTest(input string name, input aluOp_t tOp, input vecVal_t tA,
		input vecVal_t tB, input tid_t tTid, input vecVal_t expRes, input tid_t expTid,
		output logic timedOut);
		int i;
		int errs;
		int extra;
		begin
			errs = 0;
			timedOut = 1'b0;
			// Operands and req change together on the falling edge
			@(negedge clk);
			op = tOp;
			a = tA;
			b = tB;
			tidIn = tTid;
			req = 1'b1;
			for (i = 0; i < ackTimeout && !ack; i++) begin
				@(negedge clk);
			end
			if (!ack) begin
				$display("Test %s: ack did not rise within %0d cycles of req", name, ackTimeout);
				timedOut = 1'b1;
				errs++;
			end else begin
				if (res !== expRes) begin
					$display("[ERROR] %s: res expected %h, actual %h", name, expRes, res);
					errs++;
				end
				if (tidOut !== expTid) begin
					$display("[ERROR] %s: tidOut expected %h, actual %h", name, expTid, tidOut);
					errs++;
				end
				// Host keeps req up a little longer and the result must not move
				extra = $random(seed) % (maxHold + 1);
				if (extra < 0) begin
					extra = -extra;
				end
				for (i = 0; i < extra; i++) begin
					@(negedge clk);
					if (ack !== 1'b1) begin
						$display("Test %s: ack fell while req was still high", name);
						errs++;
					end
					if (res !== expRes) begin
						$display("[ERROR] %s: held res expected %h, actual %h", name, expRes, res);
						errs++;
					end
					if (tidOut !== expTid) begin
						$display("[ERROR] %s: held tidOut expected %h, actual %h", name, expTid,
							tidOut);
						errs++;
					end
				end
				req = 1'b0;
				@(negedge clk);
				for (i = 0; i < ackTimeout && ack; i++) begin
					@(negedge clk);
				end
				if (ack) begin
					$display("Test %s: ack stayed high %0d cycles after req fell", name, ackTimeout);
					timedOut = 1'b1;
					errs++;
				end
			end
			nTests++;
			if (errs != 0) begin
				nFail++;
			end
			$display("Test %s: %s (op %0d, tag %h, %0d extra hold cycles)", name,
				(errs == 0) ? "ok" : "FAILED", tOp, tTid, extra);
		end
	endtask

	// ========================================================================
	// Main sequence driven from the golden file
	// ========================================================================

	initial begin
		int fd;
		int code;
		string line;
		logic [8*32-1:0] nameBuf;
		logic [31:0] opVal;
		logic [31:0] tidVal;
		logic [31:0] expTidVal;
		vecVal_t aVal;
		vecVal_t bVal;
		vecVal_t expRes;
		logic timedOut;
		seed = 32'h670d4b05;
		nTests = 0;
		nFail = 0;
		abort = 1'b0;
		arstN = 1'b0;
		req = 1'b0;
		op = opAdd;
		a = '0;
		b = '0;
		tidIn = '0;
		repeat (4) @(negedge clk);
		arstN = 1'b1;
		repeat (2) @(negedge clk);
		// The port must be quiet before the first request
		if (ack !== 1'b0) begin
			$display("[ERROR] reset: ack expected 0, actual %b", ack);
			nFail++;
		end
		fd = $fopen("dv/vecAluGolden.txt", "r");
		if (fd == 0) begin
			$display("Could not open dv/vecAluGolden.txt for reading");
			abort = 1'b1;
		end
		while (!abort && !$feof(fd)) begin
			code = $fgets(line, fd);
			// Blank lines and lines starting with # carry no instruction
			if (code != 0 && line.len() > 1 && line.getc(0) != "#") begin
				code = $sscanf(line, "%s %h %h %h %h %h %h", nameBuf, opVal, aVal, bVal,
					tidVal, expRes, expTidVal);
				if (code != 7) begin
					$display("Golden line could not be parsed: %s", line);
					nFail++;
				end else begin
					runTest($sformatf("%0s", nameBuf), aluOp_t'(opVal[2:0]), aVal, bVal,
						tidVal[tidW-1:0], expRes, expTidVal[tidW-1:0], timedOut);
					if (timedOut) begin
						abort = 1'b1;
					end
				end
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		$display("Tests run: %0d, failed: %0d, passed: %0d", nTests, nFail, nTests - nFail);
		if (!abort && nFail == 0 && nTests > 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/vecAluGolden.txt
# name op a(lane3..lane0) b(lane3..lane0) tidIn expRes(lane3..lane0) expTid
# op 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 mul, 6 divu, 7 remu
add0 0 1234567880000001FFFFFFFF0000000A 11111111800000020000000100000005 3 2345678900000003000000000000000F 3
sub0 1 0000000589ABCDEF0000000000000010 0000000A012345670000000100000001 5 FFFFFFFB88888888FFFFFFFF0000000F 5
and0 2 AAAAAAAAFFFFFFFF12345678F0F0F0F0 55555555A5A5A5A50000FFFFFF00FF00 6 00000000A5A5A5A500005678F000F000 6
or0 3 800000000000000012340000F0F0F0F0 0000000100000000000056780F0F0F0F 7 800000010000000012345678FFFFFFFF 7
xor0 4 0000FFFFAAAAAAAADEADBEEFFFFFFFFF 00FF00FF55555555DEADBEEF12345678 8 00FFFF00FFFFFFFF00000000EDCBA987 8
mul0 5 12345678FFFFFFFF0000FFFF00000003 00000000FFFFFFFF0000FFFF00000007 9 0000000000000001FFFE000100000015 9
mul1 5 FFFFFFFF000012348000000000010000 00000002000001000000000300010000 A FFFFFFFE001234008000000000000000 A
sub1 1 0000000180000000FFFFFFFF00000000 8000000000000001FFFFFFFF00000000 2 800000017FFFFFFF0000000000000000 2
divu0 6 0000000512345678FFFFFFFF00000064 0000000A000000000000001000000007 B 00000000FFFFFFFF0FFFFFFF0000000E B
remu0 7 0000000512345678FFFFFFFF00000064 0000000A000000000000001000000007 C 00000005123456780000000F00000002 C
divu1 6 000003E8DEADBEEF0000000080000000 00000003DEADBEEF0000000000000002 D 0000014D00000001FFFFFFFF40000000 D
remu1 7 000003E8DEADBEEF0000000080000000 00000003DEADBEEF0000000000000002 E 00000001000000000000000000000000 E
add1 0 00000000FFFFFFFE000001007FFFFFFF 00000000000000030000020000000001 F 00000000000000010000030080000000 F

//--- tb.f
common/vecAluPkg.sv
vecAlu/vecAluMulDiv.sv
vecAlu/vecAluLane.sv
vecAlu/vecAlu.sv
src/vecAluReqAck.sv
src/vecAluTop.sv
dv/vecAluTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the vector ALU testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f tb.f --top-module vecAluTb -Mdir obj_dir -o vecAluSim \
	&& ./obj_dir/vecAluSim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "Simulation reported a failure"; exit 1; } \
	|| grep -q "RESULT: PASS" sim.log \
	|| { echo "No result found in sim.log"; exit 1; }
